/* verilog/fpFormatPkg.sv */
`default_nettype none

// Field layout and operand classes shared by every pipeline stage
package fpFormatPkg;

	// Half precision by default
	localparam int defExpWidth = 5;		// Biased exponent field
	localparam int defManWidth = 10;	// Stored fraction, hidden bit not counted

	// Extra bits kept below the significand LSB while aligning
	// Guard at the top, sticky at the bottom
	localparam int grsWidth = 3;

	// Class of an input operand
	// Also carried down the pipe as the special class of the result
	typedef enum logic [1:0] {
		clsNormal = 2'd0,	// Finite, nonzero
		clsZero   = 2'd1,	// Zero, subnormals land here too
		clsInf    = 2'd2,	// All-ones exponent, zero fraction
		clsNaN    = 2'd3	// All-ones exponent, nonzero fraction
	} operandClass_t;

endpackage

`default_nettype wire

/* verilog/fpAddPkg.sv */
`default_nettype none

// Operation codes and status word layout of the adder
package fpAddPkg;

	// Requested operation, one per item
	typedef enum logic {
		opAdd = 1'b0,
		opSub = 1'b1	// Flips sign of b before the add
	} fpOp_t;

	// Exception flag word
	localparam int numFlags = 4;

	// Bit positions inside the flag word
	typedef enum logic [1:0] {
		flagInexact   = 2'd0,
		flagInvalid   = 2'd1,
		flagUnderflow = 2'd2,
		flagOverflow  = 2'd3
	} flagIdx_t;

	// Input edge to output edge, one register per stage
	localparam int pipeLatency = 5;

endpackage

`default_nettype wire

/* verilog/fpUnpack.sv */
`default_nettype none

// Stage 1: classify, resolve effective op, order by magnitude
module fpUnpack #(
	parameter int expWidth = fpFormatPkg::defExpWidth,
	parameter int manWidth = fpFormatPkg::defManWidth
) (
	input  wire logic                         clk,
	input  wire logic                         rst,
	input  wire logic                         inValid,
	input  wire fpAddPkg::fpOp_t              op,
	input  wire logic [expWidth+manWidth:0]   a,
	input  wire logic [expWidth+manWidth:0]   b,
	output logic                              valid,
	output logic                              sign,
	output fpFormatPkg::operandClass_t        specialClass,
	output logic                              effSub,
	output logic [expWidth-1:0]               bigExp,
	output logic [manWidth:0]                 bigSig,	// Hidden bit restored
	output logic [manWidth:0]                 smallSig,
	output logic [expWidth-1:0]               expDiff
);
	import fpFormatPkg::*;
	import fpAddPkg::*;

	logic aSign;
	logic bSign;	// Already flipped for subtract
	logic [expWidth-1:0] aExp;
	logic [expWidth-1:0] bExp;
	logic [manWidth-1:0] aFrac;
	logic [manWidth-1:0] bFrac;
	operandClass_t aClass;
	operandClass_t bClass;
	logic [expWidth+manWidth-1:0] aMag;	// Exponent and fraction, sign dropped
	logic [expWidth+manWidth-1:0] bMag;
	logic [manWidth:0] aSig;
	logic [manWidth:0] bSig;
	logic swap;	// b is the larger magnitude
	operandClass_t classNext;
	logic signNext;

	function automatic operandClass_t classify(input logic [expWidth-1:0] exp,
		input logic [manWidth-1:0] frac);
		if (exp == '0)
			return clsZero;	// Subnormal read as zero
		if (&exp)
			return (frac == '0) ? clsInf : clsNaN;
		return clsNormal;
	endfunction

	assign aSign = a[expWidth+manWidth];
	assign bSign = b[expWidth+manWidth] ^ (op == opSub);
	assign aExp = a[expWidth+manWidth-1:manWidth];
	assign bExp = b[expWidth+manWidth-1:manWidth];
	assign aFrac = a[manWidth-1:0];
	assign bFrac = b[manWidth-1:0];
	assign aClass = classify(aExp, aFrac);
	assign bClass = classify(bExp, bFrac);

	// Subnormal fraction must not win the compare
	assign aMag = (aClass == clsZero) ? '0 : {aExp, aFrac};
	assign bMag = (bClass == clsZero) ? '0 : {bExp, bFrac};
	assign aSig = (aClass == clsZero) ? '0 : {1'b1, aFrac};
	assign bSig = (bClass == clsZero) ? '0 : {1'b1, bFrac};
	assign swap = aMag < bMag;

	// Result class is settled here once and only carried afterwards
	always_comb begin
		classNext = clsNormal;
		signNext = swap ? bSign : aSign;	// Larger operand decides
		if (aClass == clsNaN || bClass == clsNaN) begin
			classNext = clsNaN;
			signNext = 1'b0;	// Canonical NaN is positive
		end else if (aClass == clsInf && bClass == clsInf && aSign != bSign) begin
			classNext = clsNaN;	// Inf - Inf
			signNext = 1'b0;
		end else if (aClass == clsInf || bClass == clsInf) begin
			classNext = clsInf;
			signNext = (aClass == clsInf) ? aSign : bSign;
		end else if (aSign != bSign && aMag == bMag) begin
			// Exact cancellation of opposite signs is +0 under RNE
			signNext = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= 1'b0;
		end else begin
			valid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		sign <= signNext;
		specialClass <= classNext;
		effSub <= aSign ^ bSign;
		bigExp <= swap ? bExp : aExp;
		bigSig <= swap ? bSig : aSig;
		smallSig <= swap ? aSig : bSig;
		expDiff <= swap ? bExp - aExp : aExp - bExp;	// Never negative
	end

endmodule

`default_nettype wire

/* verilog/fpAlign.sv */
`default_nettype none

// Stage 2: right-shift the smaller significand, collect sticky
module fpAlign #(
	parameter int expWidth = fpFormatPkg::defExpWidth,
	parameter int manWidth = fpFormatPkg::defManWidth
) (
	input  wire logic                                   clk,
	input  wire logic                                   rst,
	input  wire logic                                   inValid,
	input  wire logic                                   inSign,
	input  wire fpFormatPkg::operandClass_t             inClass,
	input  wire logic                                   inEffSub,
	input  wire logic [expWidth-1:0]                    inBigExp,
	input  wire logic [manWidth:0]                      inBigSig,
	input  wire logic [manWidth:0]                      smallSig,
	input  wire logic [expWidth-1:0]                    expDiff,
	output logic                                        valid,
	output logic                                        sign,
	output fpFormatPkg::operandClass_t                  specialClass,
	output logic                                        effSub,
	output logic [expWidth-1:0]                         bigExp,
	output logic [manWidth:0]                           bigSig,
	output logic [manWidth+fpFormatPkg::grsWidth:0]     alignedSig	// GRS appended
);
	import fpFormatPkg::*;

	localparam int alnWidth = manWidth + 1 + grsWidth;

	logic [2*alnWidth-1:0] shiftField;	// Upper half kept, lower half lost
	logic [2*alnWidth-1:0] shifted;
	logic sticky;
	logic [alnWidth-1:0] alignedNext;

	assign shiftField = {smallSig, {grsWidth{1'b0}}, {alnWidth{1'b0}}};
	assign shifted = shiftField >> expDiff;
	assign sticky = |shifted[alnWidth-1:0];	// Anything pushed below the field

	always_comb begin
		if (expDiff >= alnWidth) begin
			// Whole operand past the bottom, only sticky survives
			alignedNext = {{(alnWidth-1){1'b0}}, |smallSig};
		end else begin
			alignedNext = {shifted[2*alnWidth-1:alnWidth+1], shifted[alnWidth] | sticky};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= 1'b0;
		end else begin
			valid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		sign <= inSign;
		specialClass <= inClass;
		effSub <= inEffSub;
		bigExp <= inBigExp;
		bigSig <= inBigSig;
		alignedSig <= alignedNext;
	end

endmodule

`default_nettype wire

/* verilog/fpMantAdd.sv */
`default_nettype none

// Stage 3: significand add or subtract
module fpMantAdd #(
	parameter int expWidth = fpFormatPkg::defExpWidth,
	parameter int manWidth = fpFormatPkg::defManWidth
) (
	input  wire logic                                   clk,
	input  wire logic                                   rst,
	input  wire logic                                   inValid,
	input  wire logic                                   inSign,
	input  wire fpFormatPkg::operandClass_t             inClass,
	input  wire logic                                   effSub,
	input  wire logic [expWidth-1:0]                    inBigExp,
	input  wire logic [manWidth:0]                      bigSig,
	input  wire logic [manWidth+fpFormatPkg::grsWidth:0] alignedSig,
	output logic                                        valid,
	output logic                                        sign,
	output fpFormatPkg::operandClass_t                  specialClass,
	output logic [expWidth-1:0]                         bigExp,
	output logic [manWidth+fpFormatPkg::grsWidth+1:0]   sum	// Top bit is carry
);
	import fpFormatPkg::*;

	localparam int sumWidth = manWidth + grsWidth + 2;

	logic [sumWidth-1:0] bigExt;	// Zero GRS below the larger significand
	logic [sumWidth-1:0] smallExt;
	logic [sumWidth-1:0] sumNext;

	assign bigExt = {1'b0, bigSig, {grsWidth{1'b0}}};
	assign smallExt = {1'b0, alignedSig};

	// Magnitude ordering in stage 1 keeps the difference non-negative
	assign sumNext = effSub ? bigExt - smallExt : bigExt + smallExt;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= 1'b0;
		end else begin
			valid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		sign <= inSign;
		specialClass <= inClass;
		bigExp <= inBigExp;
		sum <= sumNext;
	end

endmodule

`default_nettype wire

/* verilog/fpNormalize.sv */
`default_nettype none

// Stage 4: leading zero count, shift and exponent fix-up
module fpNormalize #(
	parameter int expWidth = fpFormatPkg::defExpWidth,
	parameter int manWidth = fpFormatPkg::defManWidth
) (
	input  wire logic                                   clk,
	input  wire logic                                   rst,
	input  wire logic                                   inValid,
	input  wire logic                                   inSign,
	input  wire fpFormatPkg::operandClass_t             inClass,
	input  wire logic [expWidth-1:0]                    bigExp,
	input  wire logic [manWidth+fpFormatPkg::grsWidth+1:0] sum,
	output logic                                        valid,
	output logic                                        sign,
	output fpFormatPkg::operandClass_t                  specialClass,
	output logic signed [expWidth:0]                    normExp,	// May go below 1
	output logic [manWidth+fpFormatPkg::grsWidth:0]     normSig,	// Hidden bit at top
	output logic                                        exactZero
);
	import fpFormatPkg::*;

	localparam int alnWidth = manWidth + 1 + grsWidth;
	localparam int lzcWidth = $clog2(alnWidth + 1);

	logic carry;
	logic [lzcWidth-1:0] lzc;
	logic [alnWidth-1:0] sigNext;
	logic signed [expWidth:0] expNext;

	assign carry = sum[alnWidth];

	// Highest set bit wins, all-zero sum gives full width
	always_comb begin
		lzc = lzcWidth'(alnWidth);
		for (int i = 0; i < alnWidth; i++) begin
			if (sum[i])
				lzc = lzcWidth'(alnWidth - 1 - i);
		end
	end

	always_comb begin
		if (carry) begin
			sigNext = {sum[alnWidth:2], sum[1] | sum[0]};	// Keep sticky
			expNext = $signed({1'b0, bigExp} + 1'b1);
		end else begin
			sigNext = sum[alnWidth-1:0] << lzc;
			expNext = $signed({1'b0, bigExp}) - $signed((expWidth+1)'(lzc));
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= 1'b0;
		end else begin
			valid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		sign <= inSign;
		specialClass <= inClass;
		normExp <= expNext;
		normSig <= sigNext;
		exactZero <= (sum == '0);	// Cancellation or zero operands
	end

endmodule

`default_nettype wire

/* verilog/fpRound.sv */
`default_nettype none

// Stage 5: RNE rounding, range checks, special results and flags
module fpRound #(
	parameter int expWidth = fpFormatPkg::defExpWidth,
	parameter int manWidth = fpFormatPkg::defManWidth
) (
	input  wire logic                                   clk,
	input  wire logic                                   rst,
	input  wire logic                                   valid,
	input  wire logic                                   sign,
	input  wire fpFormatPkg::operandClass_t             specialClass,
	input  wire logic signed [expWidth:0]               normExp,
	input  wire logic [manWidth+fpFormatPkg::grsWidth:0] normSig,
	input  wire logic                                   exactZero,
	output logic                                        outValid,
	output logic [expWidth+manWidth:0]                  result,
	output logic [fpAddPkg::numFlags-1:0]               flags
);
	import fpFormatPkg::*;
	import fpAddPkg::*;

	localparam int alnWidth = manWidth + 1 + grsWidth;
	localparam logic [expWidth-1:0] expOnes = '1;

	logic guard;
	logic roundBit;
	logic sticky;
	logic lsb;	// Fraction LSB, breaks ties
	logic lost;	// Any discarded bit set
	logic roundUp;
	logic [manWidth+1:0] rounded;	// Extra top bit catches carry-out
	logic signed [expWidth+1:0] roundExp;
	logic [manWidth-1:0] fracOut;
	logic [expWidth+manWidth:0] resultNext;
	logic [numFlags-1:0] flagsNext;

	assign guard = normSig[grsWidth-1];
	assign roundBit = normSig[grsWidth-2];
	assign sticky = |normSig[grsWidth-3:0];
	assign lsb = normSig[grsWidth];
	assign lost = guard | roundBit | sticky;
	assign roundUp = guard & (roundBit | sticky | lsb);	// Nearest, ties to even

	assign rounded = {1'b0, normSig[alnWidth-1:grsWidth]} + {{(manWidth+1){1'b0}}, roundUp};

	// Carry-out from 1.11..1 renormalizes by one
	assign roundExp = (expWidth+2)'(normExp) + $signed({1'b0, rounded[manWidth+1]});
	assign fracOut = rounded[manWidth+1] ? rounded[manWidth:1] : rounded[manWidth-1:0];

	always_comb begin
		resultNext = {sign, roundExp[expWidth-1:0], fracOut};
		flagsNext = '0;
		flagsNext[flagInexact] = lost;
		if (specialClass == clsNaN) begin
			resultNext = {1'b0, expOnes, 1'b1, {(manWidth-1){1'b0}}};	// Quiet NaN
			flagsNext = '0;
			flagsNext[flagInvalid] = 1'b1;
		end else if (specialClass == clsInf) begin
			resultNext = {sign, expOnes, {manWidth{1'b0}}};
			flagsNext = '0;	// Exact infinity from an infinite operand
		end else if (exactZero) begin
			// Sign already +0 for opposite-sign cancellation
			resultNext = {sign, {(expWidth+manWidth){1'b0}}};
			flagsNext = '0;
		end else if (roundExp >= $signed({2'b00, expOnes})) begin
			resultNext = {sign, expOnes, {manWidth{1'b0}}};	// Overflow to inf
			flagsNext[flagOverflow] = 1'b1;
			flagsNext[flagInexact] = 1'b1;
		end else if (roundExp < 1) begin
			resultNext = {sign, {(expWidth+manWidth){1'b0}}};	// Flush, no subnormals
			flagsNext[flagUnderflow] = 1'b1;
			flagsNext[flagInexact] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else begin
			outValid <= valid;
		end
	end

	// Meaningless while outValid is low
	always_ff @(posedge clk) begin
		result <= resultNext;
		flags <= flagsNext;
	end

endmodule

`default_nettype wire

/* verilog/fpAddSub.sv */
`default_nettype none

// Five-stage FP add/sub, one operation accepted per cycle
module fpAddSub #(
	parameter int expWidth = fpFormatPkg::defExpWidth,
	parameter int manWidth = fpFormatPkg::defManWidth
) (
	input  wire logic                          clk,
	input  wire logic                          rst,
	input  wire logic                          inValid,
	input  wire fpAddPkg::fpOp_t               op,
	input  wire logic [expWidth+manWidth:0]    a,
	input  wire logic [expWidth+manWidth:0]    b,
	output logic                               outValid,
	output logic [expWidth+manWidth:0]         result,
	output logic [fpAddPkg::numFlags-1:0]      flags
);
	import fpFormatPkg::*;

	// Unpack to align
	logic upValid;
	logic upSign;
	operandClass_t upClass;
	logic upEffSub;
	logic [expWidth-1:0] upBigExp;
	logic [manWidth:0] upBigSig;
	logic [manWidth:0] upSmallSig;
	logic [expWidth-1:0] upExpDiff;

	// Align to add
	logic alValid;
	logic alSign;
	operandClass_t alClass;
	logic alEffSub;
	logic [expWidth-1:0] alBigExp;
	logic [manWidth:0] alBigSig;
	logic [manWidth+grsWidth:0] alAlignedSig;

	// Add to normalize
	logic addValid;
	logic addSign;
	operandClass_t addClass;
	logic [expWidth-1:0] addBigExp;
	logic [manWidth+grsWidth+1:0] addSum;

	// Normalize to round
	logic nrmValid;
	logic nrmSign;
	operandClass_t nrmClass;
	logic signed [expWidth:0] nrmExp;
	logic [manWidth+grsWidth:0] nrmSig;
	logic nrmExactZero;

	fpUnpack #(.expWidth(expWidth), .manWidth(manWidth)) uUnpack (
		.clk(clk), .rst(rst), .inValid(inValid), .op(op), .a(a), .b(b),
		.valid(upValid), .sign(upSign), .specialClass(upClass), .effSub(upEffSub),
		.bigExp(upBigExp), .bigSig(upBigSig), .smallSig(upSmallSig), .expDiff(upExpDiff)
	);

	fpAlign #(.expWidth(expWidth), .manWidth(manWidth)) uAlign (
		.clk(clk), .rst(rst), .inValid(upValid), .inSign(upSign), .inClass(upClass),
		.inEffSub(upEffSub), .inBigExp(upBigExp), .inBigSig(upBigSig),
		.smallSig(upSmallSig), .expDiff(upExpDiff),
		.valid(alValid), .sign(alSign), .specialClass(alClass), .effSub(alEffSub),
		.bigExp(alBigExp), .bigSig(alBigSig), .alignedSig(alAlignedSig)
	);

	fpMantAdd #(.expWidth(expWidth), .manWidth(manWidth)) uMantAdd (
		.clk(clk), .rst(rst), .inValid(alValid), .inSign(alSign), .inClass(alClass),
		.effSub(alEffSub), .inBigExp(alBigExp), .bigSig(alBigSig), .alignedSig(alAlignedSig),
		.valid(addValid), .sign(addSign), .specialClass(addClass), .bigExp(addBigExp),
		.sum(addSum)
	);

	fpNormalize #(.expWidth(expWidth), .manWidth(manWidth)) uNormalize (
		.clk(clk), .rst(rst), .inValid(addValid), .inSign(addSign), .inClass(addClass),
		.bigExp(addBigExp), .sum(addSum),
		.valid(nrmValid), .sign(nrmSign), .specialClass(nrmClass), .normExp(nrmExp),
		.normSig(nrmSig), .exactZero(nrmExactZero)
	);

	fpRound #(.expWidth(expWidth), .manWidth(manWidth)) uRound (
		.clk(clk), .rst(rst), .valid(nrmValid), .sign(nrmSign), .specialClass(nrmClass),
		.normExp(nrmExp), .normSig(nrmSig), .exactZero(nrmExactZero),
		.outValid(outValid), .result(result), .flags(flags)
	);

endmodule

`default_nettype wire

/* verification/fpAddModel.svh */
`ifndef FPADDMODEL_SVH
`define FPADDMODEL_SVH
`default_nettype none

// Half precision reference, returns {flags, result}
// Exact sum held as an integer in units of 2^-24
function automatic logic [numFlags+15:0] addModel(input logic [15:0] x, input logic [15:0] y,
	input logic sub);
	logic xSign;
	logic ySign;	// Effective sign, flipped for subtract
	logic [4:0] xExp;
	logic [4:0] yExp;
	logic [9:0] xFrac;
	logic [9:0] yFrac;
	logic xNaN;
	logic yNaN;
	logic xInf;
	logic yInf;
	logic resSign;
	logic [numFlags-1:0] fl;
	longint xVal;
	longint yVal;
	longint total;
	longint mag;
	longint sig;
	longint rem;
	longint half;
	int msb;
	int shift;
	int expOut;

	fl = '0;
	xSign = x[15];
	ySign = y[15] ^ sub;
	xExp = x[14:10];
	yExp = y[14:10];
	xFrac = x[9:0];
	yFrac = y[9:0];
	xNaN = (xExp == 5'h1F) && (xFrac != 0);
	yNaN = (yExp == 5'h1F) && (yFrac != 0);
	xInf = (xExp == 5'h1F) && (xFrac == 0);
	yInf = (yExp == 5'h1F) && (yFrac == 0);

	// NaN in, or inf minus inf
	if (xNaN || yNaN || (xInf && yInf && xSign != ySign)) begin
		fl[flagInvalid] = 1'b1;
		return {fl, 16'h7E00};
	end
	if (xInf || yInf)
		return {fl, (xInf ? xSign : ySign), 5'h1F, 10'h000};	// Exact, no flags

	// Subnormals count as zero
	xVal = (xExp == 0) ? 0 : longint'({1'b1, xFrac}) << (xExp - 1);
	yVal = (yExp == 0) ? 0 : longint'({1'b1, yFrac}) << (yExp - 1);
	total = (xSign ? -xVal : xVal) + (ySign ? -yVal : yVal);

	if (total == 0)
		return {fl, ((xSign == ySign) ? xSign : 1'b0), 15'h0000};	// Opposite signs give +0

	resSign = total < 0;
	mag = resSign ? -total : total;
	msb = 0;
	for (int i = 0; i < 63; i++) begin
		if (mag[i])
			msb = i;
	end
	expOut = msb - 9;	// Hidden bit at position 10 means exponent 1

	if (msb > 10) begin
		shift = msb - 10;
		sig = mag >> shift;
		rem = mag & ((longint'(1) << shift) - 1);
		half = longint'(1) << (shift - 1);
		if (rem != 0)
			fl[flagInexact] = 1'b1;
		if (rem > half || (rem == half && sig[0]))
			sig++;	// Nearest, ties to even
		if (sig == 2048) begin
			sig = 1024;
			expOut++;
		end
	end else begin
		sig = mag << (10 - msb);
	end

	if (expOut >= 31) begin
		fl[flagOverflow] = 1'b1;
		fl[flagInexact] = 1'b1;
		return {fl, resSign, 5'h1F, 10'h000};
	end
	if (expOut < 1) begin
		fl[flagUnderflow] = 1'b1;	// Flush to signed zero
		fl[flagInexact] = 1'b1;
		return {fl, resSign, 15'h0000};
	end
	return {fl, resSign, expOut[4:0], sig[9:0]};
endfunction

`default_nettype wire
`endif

/* verification/fpAddSubTb.sv */
`default_nettype none

module fpAddSubTb;
	import fpFormatPkg::*;
	import fpAddPkg::*;

	localparam int dataW = defExpWidth + defManWidth + 1;
	localparam int numOps = 3000;
	localparam int resetCycles = 4;

	logic clk;
	logic rst;
	logic inValid;
	fpOp_t op;
	logic [dataW-1:0] a;
	logic [dataW-1:0] b;
	logic outValid;
	logic [dataW-1:0] result;
	logic [numFlags-1:0] flags;

	integer seed;
	int edgeCount;	// Rising edges seen so far
	int accepted;

	// Expected values in issue order
	logic [numFlags+dataW-1:0] expQ[$];
	int edgeQ[$];	// Edge after which the operands were driven
	int catQ[$];
	logic [2*dataW:0] stimQ[$];	// {op, a, b} for error lines

	logic [numFlags+dataW-1:0] chkExp;
	int chkEdge;
	int chkCat;
	logic [2*dataW:0] chkStim;

	`include "fpAddModel.svh"

	fpAddSub DUT (
		.clk(clk), .rst(rst), .inValid(inValid), .op(op), .a(a), .b(b),
		.outValid(outValid), .result(result), .flags(flags)
	);

	always #4 clk = ~clk;

	always @(posedge clk) edgeCount <= edgeCount + 1;

	function automatic string catName(input int c);
		case (c)
			2: return "nearExp";
			3: return "special";
			4: return "large";
			5: return "cancel";
			6: return "tiny";
			7: return "zero";
			default: return "random";
		endcase
	endfunction

	// Mixed operand classes with the category picked per operation
	task automatic makeOperands(output int cat, output logic [dataW-1:0] x,
		output logic [dataW-1:0] y, output fpOp_t o);
		int near;
		cat = $random(seed) & 7;
		x = $random(seed);
		y = $random(seed);
		o = ($random(seed) & 1) ? opSub : opAdd;
		case (cat)
			2: begin	// Exponents within one to hit ties and GRS
				near = int'(x[14:10]) + ($random(seed) % 2);
				if (near < 1)
					near = 1;
				if (near > 30)
					near = 30;
				y[14:10] = near[4:0];
			end
			3: begin
				x[14:10] = 5'h1F;
				if ($random(seed) & 1)
					x[9:0] = '0;	// Infinity or else mostly NaN
				if ($random(seed) & 1)
					y = {y[15], 5'h1F, 10'h000};
			end
			4: begin	// Same sign near the top of the range
				x[14:10] = 5'd29 + ($random(seed) & 1);
				y[14:10] = 5'd29 + ($random(seed) & 1);
				y[15] = x[15];
				o = opAdd;
			end
			5: begin
				if (x[14:10] == 0 || x[14:10] == 5'h1F)
					x[14:10] = 5'd15;
				y = x;
				o = opSub;
				if ($random(seed) & 1) begin
					y[15] = ~x[15];	// Same cancel through an add
					o = opAdd;
				end
			end
			6: begin	// Close values at the bottom exponents
				x[14:10] = 5'd1 + ($random(seed) & 1);
				y[14:0] = {x[14:4], y[3:0]};
				y[15] = x[15];
				o = opSub;
			end
			7: begin
				x[14:10] = '0;
				if ($random(seed) & 1)
					x[9:0] = '0;
				if ($random(seed) & 1)
					y[14:0] = '0;
			end
			default: ;
		endcase
	endtask

	initial begin
		seed = 43542;
		clk = 1'b0;
		rst = 1'b1;
		inValid = 1'b0;
		op = opAdd;
		a = '0;
		b = '0;
		edgeCount = 0;
		accepted = 0;
	end

	// Drive 1 unit after each rising edge
	initial begin : stimulus
		int cat;
		logic [dataW-1:0] x;
		logic [dataW-1:0] y;
		fpOp_t o;
		repeat (resetCycles) @(posedge clk);
		#1 rst = 1'b0;
		while (accepted < numOps) begin
			@(posedge clk);
			#1;
			if (($random(seed) & 3) != 0) begin	// About 3 in 4 cycles
				makeOperands(cat, x, y, o);
				a = x;
				b = y;
				op = o;
				inValid = 1'b1;
				expQ.push_back(addModel(x, y, o == opSub));
				edgeQ.push_back(edgeCount);
				catQ.push_back(cat);
				stimQ.push_back({o, x, y});
				accepted++;
			end else begin
				inValid = 1'b0;
				a = $random(seed);	// Junk while idle
				b = $random(seed);
			end
		end
		@(posedge clk);
		#1 inValid = 1'b0;
		while (edgeQ.size() != 0) @(posedge clk);
		repeat (pipeLatency + 2) @(posedge clk);	// Catch stray outValid
		$display("Test OK");
		$finish;
	end

	// Outputs are stable at the falling edge
	always @(negedge clk) begin
		if (!rst) begin
			if (outValid === 1'b1) begin
				assert (edgeQ.size() != 0) else begin
					$display("Output valid at edge %0d with no operation in flight", edgeCount);
					$display("Test FAILED");
					$fatal(1, "unexpected output");
				end
				chkExp = expQ.pop_front();
				chkEdge = edgeQ.pop_front();
				chkCat = catQ.pop_front();
				chkStim = stimQ.pop_front();
				assert (edgeCount == chkEdge + pipeLatency) else begin
					$display("FAILED %s latency: expected edge %0d actual edge %0d",
						catName(chkCat), chkEdge + pipeLatency, edgeCount);
					$display("Test FAILED");
					$fatal(1, "latency mismatch");
				end
				assert (result === chkExp[dataW-1:0] && flags === chkExp[numFlags+dataW-1:dataW])
				else begin
					$display("FAILED %s: expected %h flags %b actual %h flags %b (op %0d a %h b %h)",
						catName(chkCat), chkExp[dataW-1:0], chkExp[numFlags+dataW-1:dataW],
						result, flags, chkStim[2*dataW], chkStim[2*dataW-1:dataW],
						chkStim[dataW-1:0]);
					$display("Test FAILED");
					$fatal(1, "result mismatch");
				end
			end else begin
				assert (edgeQ.size() == 0 || edgeQ[0] + pipeLatency > edgeCount) else begin
					$display("Output for the operation from edge %0d never became valid",
						edgeQ[0]);
					$display("Test FAILED");
					$fatal(1, "missing output");
				end
			end
		end
	end

	// Worst case two cycles per operation plus reset and drain
	initial begin
		#((numOps * 2 + resetCycles + pipeLatency + 20) * 8);
		$display("Timeout: the run did not finish in time, %0d results pending", edgeQ.size());
		$display("Test FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

/* fpAddSub.f */
+incdir+verification
verilog/fpFormatPkg.sv
verilog/fpAddPkg.sv
verilog/fpUnpack.sv
verilog/fpAlign.sv
verilog/fpMantAdd.sv
verilog/fpNormalize.sv
verilog/fpRound.sv
verilog/fpAddSub.sv
verification/fpAddSubTb.sv

/* Bender.yml */
package:
  name: fpAddSub

sources:
  - files:
      - verilog/fpFormatPkg.sv
      - verilog/fpAddPkg.sv
      - verilog/fpUnpack.sv
      - verilog/fpAlign.sv
      - verilog/fpMantAdd.sv
      - verilog/fpNormalize.sv
      - verilog/fpRound.sv
      - verilog/fpAddSub.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/fpAddSubTb.sv
